//--- logic/idu_pkg.sv
// decode types, operation indices, alu, branch, memory, source and format codes
package idu_pkg;

  typedef logic [31:0] inst_t;
  typedef logic [63:0] xlen_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [5:0]  op_t;
  typedef logic [2:0]  fmt_t;
  typedef logic [4:0]  alu_ctr_t;
  typedef logic [2:0]  branch_t;
  typedef logic [2:0]  mem_op_t;
  typedef logic [1:0]  alub_src_t;

  localparam op_t OP_NONE  = 6'd0;
  localparam op_t OP_LUI   = 6'd1;
  localparam op_t OP_AUIPC = 6'd2;
  localparam op_t OP_JAL   = 6'd3;
  localparam op_t OP_JALR  = 6'd4;
  localparam op_t OP_BEQ   = 6'd5;
  localparam op_t OP_BNE   = 6'd6;
  localparam op_t OP_BLT   = 6'd7;
  localparam op_t OP_BGE   = 6'd8;
  localparam op_t OP_BLTU  = 6'd9;
  localparam op_t OP_BGEU  = 6'd10;
  localparam op_t OP_LB    = 6'd11;
  localparam op_t OP_LH    = 6'd12;
  localparam op_t OP_LW    = 6'd13;
  localparam op_t OP_LBU   = 6'd14;
  localparam op_t OP_LHU   = 6'd15;
  localparam op_t OP_LWU   = 6'd16;
  localparam op_t OP_LD    = 6'd17;
  localparam op_t OP_SB    = 6'd18;
  localparam op_t OP_SH    = 6'd19;
  localparam op_t OP_SW    = 6'd20;
  localparam op_t OP_SD    = 6'd21;
  localparam op_t OP_ADDI  = 6'd22;
  localparam op_t OP_SLTI  = 6'd23;
  localparam op_t OP_SLTIU = 6'd24;
  localparam op_t OP_XORI  = 6'd25;
  localparam op_t OP_ORI   = 6'd26;
  localparam op_t OP_ANDI  = 6'd27;
  localparam op_t OP_SLLI  = 6'd28;
  localparam op_t OP_SRLI  = 6'd29;
  localparam op_t OP_SRAI  = 6'd30;
  localparam op_t OP_ADD   = 6'd31;
  localparam op_t OP_SUB   = 6'd32;
  localparam op_t OP_SLL   = 6'd33;
  localparam op_t OP_SLT   = 6'd34;
  localparam op_t OP_SLTU  = 6'd35;
  localparam op_t OP_XOR   = 6'd36;
  localparam op_t OP_SRL   = 6'd37;
  localparam op_t OP_SRA   = 6'd38;
  localparam op_t OP_OR    = 6'd39;
  localparam op_t OP_AND   = 6'd40;
  localparam op_t OP_ADDIW = 6'd41;
  localparam op_t OP_SLLIW = 6'd42;
  localparam op_t OP_SRLIW = 6'd43;
  localparam op_t OP_SRAIW = 6'd44;
  localparam op_t OP_ADDW  = 6'd45;
  localparam op_t OP_SUBW  = 6'd46;
  localparam op_t OP_SLLW  = 6'd47;
  localparam op_t OP_SRLW  = 6'd48;
  localparam op_t OP_SRAW  = 6'd49;

  localparam fmt_t FMT_R    = 3'd0;
  localparam fmt_t FMT_I    = 3'd1;
  localparam fmt_t FMT_S    = 3'd2;
  localparam fmt_t FMT_B    = 3'd3;
  localparam fmt_t FMT_U    = 3'd4;
  localparam fmt_t FMT_J    = 3'd5;
  localparam fmt_t FMT_NONE = 3'd7;

  localparam alu_ctr_t ALU_ADD     = 5'd0;
  localparam alu_ctr_t ALU_SUB     = 5'd1;
  localparam alu_ctr_t ALU_SLT     = 5'd2;
  localparam alu_ctr_t ALU_SLTU    = 5'd3;
  localparam alu_ctr_t ALU_XOR     = 5'd4;
  localparam alu_ctr_t ALU_AND     = 5'd5;
  localparam alu_ctr_t ALU_OR      = 5'd6;
  localparam alu_ctr_t ALU_SLL     = 5'd7;
  localparam alu_ctr_t ALU_SRL     = 5'd8;
  localparam alu_ctr_t ALU_SRA     = 5'd9;
  localparam alu_ctr_t ALU_COPYIMM = 5'd15;
  localparam alu_ctr_t ALU_INVALID = 5'd31;

  localparam branch_t BR_NONE = 3'd0;
  localparam branch_t BR_JAL  = 3'd1;
  localparam branch_t BR_JALR = 3'd2;
  localparam branch_t BR_EQ   = 3'd4;
  localparam branch_t BR_NE   = 3'd5;
  localparam branch_t BR_LT   = 3'd6; // blt and bltu
  localparam branch_t BR_GE   = 3'd7; // bge and bgeu

  localparam mem_op_t MEM_BS   = 3'd0;
  localparam mem_op_t MEM_BU   = 3'd1;
  localparam mem_op_t MEM_HS   = 3'd2;
  localparam mem_op_t MEM_HU   = 3'd3;
  localparam mem_op_t MEM_WS   = 3'd4;
  localparam mem_op_t MEM_WU   = 3'd5;
  localparam mem_op_t MEM_D    = 3'd6;
  localparam mem_op_t MEM_NONE = 3'd7;

  localparam alub_src_t SRCB_RS2  = 2'd0;
  localparam alub_src_t SRCB_IMM  = 2'd1;
  localparam alub_src_t SRCB_FOUR = 2'd2;

endpackage

//--- logic/idu_inst_match.sv
// opcode and funct matching to one operation index and format
`timescale 1ns/1ps

module idu_inst_match import idu_pkg::*; (
  input  inst_t i_inst,
  output op_t   o_op,
  output fmt_t  o_fmt
);

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OPIMMW = 7'b0011011;
  localparam logic [6:0] OPC_OPW    = 7'b0111011;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [9:0] f7f3;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign f7f3   = {funct7, funct3};

  always_comb begin
    o_op = OP_NONE;
    case (opcode)
      OPC_LUI:   o_op = OP_LUI;
      OPC_AUIPC: o_op = OP_AUIPC;
      OPC_JAL:   o_op = OP_JAL;
      OPC_JALR:  if (funct3 == 3'b000) o_op = OP_JALR;
      OPC_BRANCH: begin
        case (funct3)
          3'b000:  o_op = OP_BEQ;
          3'b001:  o_op = OP_BNE;
          3'b100:  o_op = OP_BLT;
          3'b101:  o_op = OP_BGE;
          3'b110:  o_op = OP_BLTU;
          3'b111:  o_op = OP_BGEU;
          default: o_op = OP_NONE;
        endcase
      end
      OPC_LOAD: begin
        case (funct3)
          3'b000:  o_op = OP_LB;
          3'b001:  o_op = OP_LH;
          3'b010:  o_op = OP_LW;
          3'b011:  o_op = OP_LD;
          3'b100:  o_op = OP_LBU;
          3'b101:  o_op = OP_LHU;
          3'b110:  o_op = OP_LWU;
          default: o_op = OP_NONE;
        endcase
      end
      OPC_STORE: begin
        case (funct3)
          3'b000:  o_op = OP_SB;
          3'b001:  o_op = OP_SH;
          3'b010:  o_op = OP_SW;
          3'b011:  o_op = OP_SD;
          default: o_op = OP_NONE;
        endcase
      end
      OPC_OPIMM: begin
        case (funct3)
          3'b000: o_op = OP_ADDI;
          3'b010: o_op = OP_SLTI;
          3'b011: o_op = OP_SLTIU;
          3'b100: o_op = OP_XORI;
          3'b110: o_op = OP_ORI;
          3'b111: o_op = OP_ANDI;
          3'b001: if (funct7[6:1] == 6'b000000) o_op = OP_SLLI; // shamt[5] in funct7[0]
          default: begin
            if (funct7[6:1] == 6'b000000) o_op = OP_SRLI;
            else if (funct7[6:1] == 6'b010000) o_op = OP_SRAI;
          end
        endcase
      end
      OPC_OP: begin
        case (f7f3)
          10'b0000000_000: o_op = OP_ADD;
          10'b0100000_000: o_op = OP_SUB;
          10'b0000000_001: o_op = OP_SLL;
          10'b0000000_010: o_op = OP_SLT;
          10'b0000000_011: o_op = OP_SLTU;
          10'b0000000_100: o_op = OP_XOR;
          10'b0000000_101: o_op = OP_SRL;
          10'b0100000_101: o_op = OP_SRA;
          10'b0000000_110: o_op = OP_OR;
          10'b0000000_111: o_op = OP_AND;
          default:         o_op = OP_NONE; // includes M extension
        endcase
      end
      OPC_OPIMMW: begin
        if (funct3 == 3'b000) o_op = OP_ADDIW;
        else if (f7f3 == 10'b0000000_001) o_op = OP_SLLIW;
        else if (f7f3 == 10'b0000000_101) o_op = OP_SRLIW;
        else if (f7f3 == 10'b0100000_101) o_op = OP_SRAIW;
      end
      OPC_OPW: begin
        case (f7f3)
          10'b0000000_000: o_op = OP_ADDW;
          10'b0100000_000: o_op = OP_SUBW;
          10'b0000000_001: o_op = OP_SLLW;
          10'b0000000_101: o_op = OP_SRLW;
          10'b0100000_101: o_op = OP_SRAW;
          default:         o_op = OP_NONE;
        endcase
      end
      default: o_op = OP_NONE;
    endcase
  end

  // format follows the opcode once the word has matched
  always_comb begin
    case (opcode)
      OPC_OP, OPC_OPW:                  o_fmt = FMT_R;
      OPC_JALR, OPC_LOAD, OPC_OPIMM,
      OPC_OPIMMW:                       o_fmt = FMT_I;
      OPC_STORE:                        o_fmt = FMT_S;
      OPC_BRANCH:                       o_fmt = FMT_B;
      OPC_LUI, OPC_AUIPC:               o_fmt = FMT_U;
      OPC_JAL:                          o_fmt = FMT_J;
      default:                          o_fmt = FMT_NONE;
    endcase
    if (o_op == OP_NONE) o_fmt = FMT_NONE;
  end

endmodule

//--- logic/idu_imm_gen.sv
// immediate builder for the i, s, b, u and j formats
`timescale 1ns/1ps

module idu_imm_gen import idu_pkg::*; (
  input  inst_t i_inst,
  input  fmt_t  i_fmt,
  output xlen_t o_imm
);

  xlen_t imm_i;
  xlen_t imm_s;
  xlen_t imm_b;
  xlen_t imm_u;
  xlen_t imm_j;

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0}; // sign from bit 31
  assign imm_j = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    case (i_fmt)
      FMT_I:   o_imm = imm_i;
      FMT_S:   o_imm = imm_s;
      FMT_B:   o_imm = imm_b;
      FMT_U:   o_imm = imm_u;
      FMT_J:   o_imm = imm_j;
      default: o_imm = '0; // r format has no immediate
    endcase
  end

endmodule

//--- logic/idu_ctrl_gen.sv
// alu, branch, memory, source select, word and write-back controls
`timescale 1ns/1ps

module idu_ctrl_gen import idu_pkg::*; (
  input  inst_t     i_inst,
  input  op_t       i_op,
  input  fmt_t      i_fmt,
  output alu_ctr_t  o_alu_ctr,
  output logic      o_alua_pc,
  output alub_src_t o_alub_src,
  output branch_t   o_branch,
  output logic      o_mem_rd,
  output logic      o_mem_wr,
  output logic      o_mem_to_reg,
  output mem_op_t   o_mem_op,
  output logic      o_word_op,
  output logic      o_reg_wr,
  output logic      o_invalid
);

  logic is_load;

  always_comb begin
    case (i_op)
      OP_LUI: o_alu_ctr = ALU_COPYIMM;
      OP_AUIPC, OP_JAL, OP_JALR, OP_ADDI, OP_ADD, OP_ADDIW, OP_ADDW,
      OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU, OP_LD,
      OP_SB, OP_SH, OP_SW, OP_SD:
        o_alu_ctr = ALU_ADD;
      OP_SUB, OP_SUBW:
        o_alu_ctr = ALU_SUB;
      OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_SLT, OP_SLTI:
        o_alu_ctr = ALU_SLT; // branches compare through slt
      OP_BLTU, OP_BGEU, OP_SLTU, OP_SLTIU:
        o_alu_ctr = ALU_SLTU;
      OP_XOR, OP_XORI: o_alu_ctr = ALU_XOR;
      OP_AND, OP_ANDI: o_alu_ctr = ALU_AND;
      OP_OR, OP_ORI:   o_alu_ctr = ALU_OR;
      OP_SLL, OP_SLLI, OP_SLLIW, OP_SLLW: o_alu_ctr = ALU_SLL;
      OP_SRL, OP_SRLI, OP_SRLIW, OP_SRLW: o_alu_ctr = ALU_SRL;
      OP_SRA, OP_SRAI, OP_SRAIW, OP_SRAW: o_alu_ctr = ALU_SRA;
      default: o_alu_ctr = ALU_INVALID;
    endcase
  end

  always_comb begin
    case (i_op)
      OP_JAL:          o_branch = BR_JAL;
      OP_JALR:         o_branch = BR_JALR;
      OP_BEQ:          o_branch = BR_EQ;
      OP_BNE:          o_branch = BR_NE;
      OP_BLT, OP_BLTU: o_branch = BR_LT;
      OP_BGE, OP_BGEU: o_branch = BR_GE;
      default:         o_branch = BR_NONE;
    endcase
  end

  // stores share the signed width codes
  always_comb begin
    case (i_op)
      OP_LB, OP_SB: o_mem_op = MEM_BS;
      OP_LBU:       o_mem_op = MEM_BU;
      OP_LH, OP_SH: o_mem_op = MEM_HS;
      OP_LHU:       o_mem_op = MEM_HU;
      OP_LW, OP_SW: o_mem_op = MEM_WS;
      OP_LWU:       o_mem_op = MEM_WU;
      OP_LD, OP_SD: o_mem_op = MEM_D;
      default:      o_mem_op = MEM_NONE;
    endcase
  end

  assign is_load      = (i_fmt == FMT_I) && (o_mem_op != MEM_NONE);
  assign o_mem_rd     = is_load;
  assign o_mem_to_reg = is_load;
  assign o_mem_wr     = (i_fmt == FMT_S);

  assign o_alua_pc = (i_op == OP_JAL) || (i_op == OP_JALR) || (i_op == OP_AUIPC);

  always_comb begin
    if ((i_op == OP_JAL) || (i_op == OP_JALR)) begin
      o_alub_src = SRCB_FOUR; // link address pc + 4
    end else if ((i_fmt == FMT_I) || (i_fmt == FMT_U) || (i_fmt == FMT_S)) begin
      o_alub_src = SRCB_IMM;
    end else begin
      o_alub_src = SRCB_RS2;
    end
  end

  always_comb begin
    case (i_op)
      OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW,
      OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW:
        o_word_op = 1'b1;
      default:
        o_word_op = 1'b0;
    endcase
  end

  assign o_reg_wr  = (i_fmt == FMT_R) || (i_fmt == FMT_I) || (i_fmt == FMT_U) ||
                     (i_fmt == FMT_J);
  assign o_invalid = (o_alu_ctr == ALU_INVALID) && (i_inst != '0); // all-zero word is a bubble

endmodule

//--- logic/idu_gpr_file.sv
// general-purpose register file, two async reads and one sync write
`timescale 1ns/1ps

module idu_gpr_file #(
  parameter int ADDR_WIDTH = 5,
  parameter int DATA_WIDTH = 64
) (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic [ADDR_WIDTH-1:0] i_raddr1,
  input  logic [ADDR_WIDTH-1:0] i_raddr2,
  input  logic [ADDR_WIDTH-1:0] i_waddr,
  input  logic [DATA_WIDTH-1:0] i_wdata,
  input  logic                  i_wen,
  output logic [DATA_WIDTH-1:0] o_rdata1,
  output logic [DATA_WIDTH-1:0] o_rdata2
);

  localparam int NUM_REGS = 2 ** ADDR_WIDTH;

  logic [DATA_WIDTH-1:0] regs [NUM_REGS];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1]; // x0 hardwired
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

//--- logic/idu.sv
// decode stage top level, field slicing and unit wiring
`timescale 1ns/1ps

module idu import idu_pkg::*; #(
  parameter int ADDR_WIDTH = 5,
  parameter int DATA_WIDTH = 64
) (
  input  logic      i_clk,
  input  logic      i_rst,
  input  inst_t     i_inst,
  input  xlen_t     i_wb_data,
  output xlen_t     o_rs1_data,
  output xlen_t     o_rs2_data,
  output xlen_t     o_imm,
  output alu_ctr_t  o_alu_ctr,
  output logic      o_alua_pc,
  output alub_src_t o_alub_src,
  output branch_t   o_branch,
  output logic      o_mem_rd,
  output logic      o_mem_wr,
  output logic      o_mem_to_reg,
  output mem_op_t   o_mem_op,
  output logic      o_word_op,
  output logic      o_invalid
);

  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  op_t       op;
  fmt_t      fmt;
  logic      reg_wr;

  assign rs1 = i_inst[19:15];
  assign rs2 = i_inst[24:20];
  assign rd  = i_inst[11:7];

  idu_inst_match u_match (
    .i_inst (i_inst),
    .o_op   (op),
    .o_fmt  (fmt)
  );

  idu_imm_gen u_imm (
    .i_inst (i_inst),
    .i_fmt  (fmt),
    .o_imm  (o_imm)
  );

  idu_ctrl_gen u_ctrl (
    .i_inst       (i_inst),
    .i_op         (op),
    .i_fmt        (fmt),
    .o_alu_ctr    (o_alu_ctr),
    .o_alua_pc    (o_alua_pc),
    .o_alub_src   (o_alub_src),
    .o_branch     (o_branch),
    .o_mem_rd     (o_mem_rd),
    .o_mem_wr     (o_mem_wr),
    .o_mem_to_reg (o_mem_to_reg),
    .o_mem_op     (o_mem_op),
    .o_word_op    (o_word_op),
    .o_reg_wr     (reg_wr),
    .o_invalid    (o_invalid)
  );

  idu_gpr_file #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) u_gprs (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .i_waddr  (rd),
    .i_wdata  (i_wb_data),
    .i_wen    (reg_wr), // write-back of the decoded instruction
    .o_rdata1 (o_rs1_data),
    .o_rdata2 (o_rs2_data)
  );

endmodule

//--- test/tb_idu_assert.sv
// concurrent decode and register file properties, bound into idu
`timescale 1ns/1ps

module tb_idu_assert import idu_pkg::*; (
  input logic     i_clk,
  input logic     i_rst,
  input inst_t    i_inst,
  input xlen_t    o_rs1_data,
  input alu_ctr_t o_alu_ctr,
  input logic     o_mem_rd,
  input logic     o_mem_wr,
  input logic     o_mem_to_reg,
  input logic     o_invalid
);

  a_mem_excl: assert property (@(posedge i_clk) disable iff (i_rst)
    !(o_mem_rd && o_mem_wr))
    else $error("memory read and write high together");

  a_load_wb: assert property (@(posedge i_clk) disable iff (i_rst)
    o_mem_rd |-> o_mem_to_reg)
    else $error("load without mem_to_reg");

  a_x0_zero: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_inst[19:15] == 5'd0) |-> (o_rs1_data == '0))
    else $error("x0 read is not zero");

  a_inv_code: assert property (@(posedge i_clk) disable iff (i_rst)
    o_invalid |-> (o_alu_ctr == ALU_INVALID))
    else $error("invalid flag with a valid alu code");

endmodule

bind idu tb_idu_assert u_assert (
  .i_clk        (i_clk),
  .i_rst        (i_rst),
  .i_inst       (i_inst),
  .o_rs1_data   (o_rs1_data),
  .o_alu_ctr    (o_alu_ctr),
  .o_mem_rd     (o_mem_rd),
  .o_mem_wr     (o_mem_wr),
  .o_mem_to_reg (o_mem_to_reg),
  .o_invalid    (o_invalid)
);

//--- test/tb_idu.sv
// testbench for idu, decode table, immediates, register file and invalid words
`timescale 1ns/1ps

module tb_idu import idu_pkg::*;;

  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

  typedef struct packed {
    inst_t     inst;
    alu_ctr_t  alu;
    alub_src_t srcb;
    logic      pc;
    logic      word;
    branch_t   br;
    mem_op_t   mop;
    xlen_t     imm;
    logic      inval;
  } entry_t;

  logic      i_clk;
  logic      i_rst;
  inst_t     i_inst;
  xlen_t     i_wb_data;
  xlen_t     o_rs1_data;
  xlen_t     o_rs2_data;
  xlen_t     o_imm;
  alu_ctr_t  o_alu_ctr;
  logic      o_alua_pc;
  alub_src_t o_alub_src;
  branch_t   o_branch;
  logic      o_mem_rd;
  logic      o_mem_wr;
  logic      o_mem_to_reg;
  mem_op_t   o_mem_op;
  logic      o_word_op;
  logic      o_invalid;

  entry_t table_q[$];
  int     errors;
  int     checks;

  idu #(.ADDR_WIDTH(5), .DATA_WIDTH(64)) dut (.*);

  always #20 i_clk = ~i_clk;

  task automatic report_timeout(string what);
    $display("timeout: %s", what);
    $display("TEST FAILED");
    $finish;
  endtask

  // waits on clock changes, gives up after a few of them
  task automatic wait_level(logic level);
    int guard;
    guard = 0;
    do begin
      @(i_clk);
      guard++;
    end while (i_clk !== level && guard < 4);
    if (i_clk !== level) report_timeout("clock edge not seen");
  endtask

  task automatic drive(inst_t inst, xlen_t wb);
    wait_level(1'b1);
    #2;
    i_inst    = inst;
    i_wb_data = wb;
  endtask

  task automatic note_error(string name, logic [63:0] got, logic [63:0] exp);
    errors++;
    $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
  endtask

  task automatic check_xlen(string name, xlen_t got, xlen_t exp);
    checks++;
    if (got !== exp) note_error(name, got, exp);
  endtask

  task automatic check_alu(string name, alu_ctr_t got, alu_ctr_t exp);
    checks++;
    if (got !== exp) note_error(name, 64'(got), 64'(exp));
  endtask

  task automatic check_srcb(string name, alub_src_t got, alub_src_t exp);
    checks++;
    if (got !== exp) note_error(name, 64'(got), 64'(exp));
  endtask

  task automatic check_branch(string name, branch_t got, branch_t exp);
    checks++;
    if (got !== exp) note_error(name, 64'(got), 64'(exp));
  endtask

  task automatic check_mem_op(string name, mem_op_t got, mem_op_t exp);
    checks++;
    if (got !== exp) note_error(name, 64'(got), 64'(exp));
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    checks++;
    if (got !== exp) note_error(name, 64'(got), 64'(exp));
  endtask

  task automatic push_entry(inst_t inst, alu_ctr_t alu, alub_src_t srcb, logic pc, logic word,
                            branch_t br, mem_op_t mop, xlen_t imm, logic inval);
    entry_t e;
    e.inst  = inst;
    e.alu   = alu;
    e.srcb  = srcb;
    e.pc    = pc;
    e.word  = word;
    e.br    = br;
    e.mop   = mop;
    e.imm   = imm;
    e.inval = inval;
    table_q.push_back(e);
  endtask

  task automatic add_i(logic [11:0] imm, logic [2:0] f3, logic [6:0] opc, alu_ctr_t alu,
                       alub_src_t srcb, logic pc, logic word, branch_t br, mem_op_t mop);
    push_entry({imm, 5'($urandom), f3, 5'($urandom), opc}, alu, srcb, pc, word, br, mop,
               {{52{imm[11]}}, imm}, 1'b0);
  endtask

  task automatic add_r(logic [6:0] f7, logic [2:0] f3, logic [6:0] opc, alu_ctr_t alu,
                       logic word);
    push_entry({f7, 5'($urandom), 5'($urandom), f3, 5'($urandom), opc}, alu, SRCB_RS2, 1'b0,
               word, BR_NONE, MEM_NONE, '0, 1'b0);
  endtask

  task automatic add_s(logic [2:0] f3, mem_op_t mop);
    logic [11:0] imm;
    imm = 12'($urandom);
    push_entry({imm[11:5], 5'($urandom), 5'($urandom), f3, imm[4:0], OPC_STORE}, ALU_ADD,
               SRCB_IMM, 1'b0, 1'b0, BR_NONE, mop, {{52{imm[11]}}, imm}, 1'b0);
  endtask

  task automatic add_b(logic [2:0] f3, alu_ctr_t alu, branch_t br);
    logic [12:0] imm;
    imm = {12'($urandom), 1'b0};
    push_entry({imm[12], imm[10:5], 5'($urandom), 5'($urandom), f3, imm[4:1], imm[11],
                7'b1100011}, alu, SRCB_RS2, 1'b0, 1'b0, br, MEM_NONE,
               {{51{imm[12]}}, imm}, 1'b0);
  endtask

  task automatic add_u(logic [6:0] opc, alu_ctr_t alu, logic pc);
    logic [19:0] imm;
    imm = 20'($urandom);
    push_entry({imm, 5'($urandom), opc}, alu, SRCB_IMM, pc, 1'b0, BR_NONE, MEM_NONE,
               {{32{imm[19]}}, imm, 12'h000}, 1'b0);
  endtask

  task automatic add_jal();
    logic [20:0] imm;
    imm = {20'($urandom), 1'b0};
    push_entry({imm[20], imm[10:1], imm[11], imm[19:12], 5'($urandom), 7'b1101111}, ALU_ADD,
               SRCB_FOUR, 1'b1, 1'b0, BR_JAL, MEM_NONE, {{43{imm[20]}}, imm}, 1'b0);
  endtask

  task automatic build_table();
    add_u(7'b0110111, ALU_COPYIMM, 1'b0); // lui
    add_u(7'b0010111, ALU_ADD, 1'b1);     // auipc
    add_jal();
    add_i(12'($urandom), 3'b000, 7'b1100111, ALU_ADD, SRCB_FOUR, 1'b1, 1'b0, BR_JALR, MEM_NONE);
    add_b(3'b000, ALU_SLT, BR_EQ);
    add_b(3'b001, ALU_SLT, BR_NE);
    add_b(3'b100, ALU_SLT, BR_LT);
    add_b(3'b101, ALU_SLT, BR_GE);
    add_b(3'b110, ALU_SLTU, BR_LT);
    add_b(3'b111, ALU_SLTU, BR_GE);
    add_i(12'($urandom), 3'b000, OPC_LOAD, ALU_ADD, SRCB_IMM, 1'b0, 1'b0, BR_NONE, MEM_BS);
    add_i(12'($urandom), 3'b001, OPC_LOAD, ALU_ADD, SRCB_IMM, 1'b0, 1'b0, BR_NONE, MEM_HS);
    add_i(12'($urandom), 3'b010, OPC_LOAD, ALU_ADD, SRCB_IMM, 1'b0, 1'b0, BR_NONE, MEM_WS);
    add_i(12'($urandom), 3'b011, OPC_LOAD, ALU_ADD, SRCB_IMM, 1'b0, 1'b0, BR_NONE, MEM_D);
    add_i(12'($urandom), 3'b100, OPC_LOAD, ALU_ADD, SRCB_IMM, 1'b0, 1'b0, BR_NONE, MEM_BU);
    add_i(12'($urandom), 3'b101, OPC_LOAD, ALU_ADD, SRCB_IMM, 1'b0, 1'b0, BR_NONE, MEM_HU);
    add_i(12'($urandom), 3'b110, OPC_LOAD, ALU_ADD, SRCB_IMM, 1'b0, 1'b0, BR_NONE, MEM_WU);
    add_s(3'b000, MEM_BS);
    add_s(3'b001, MEM_HS);
    add_s(3'b010, MEM_WS);
    add_s(3'b011, MEM_D);
    add_i(12'($urandom), 3'b000, 7'b0010011, ALU_ADD, SRCB_IMM, 1'b0, 1'b0, BR_NONE, MEM_NONE);
    add_i(12'($urandom), 3'b010, 7'b0010011, ALU_SLT, SRCB_IMM, 1'b0, 1'b0, BR_NONE, MEM_NONE);
    add_i(12'($urandom), 3'b011, 7'b0010011, ALU_SLTU, SRCB_IMM, 1'b0, 1'b0, BR_NONE, MEM_NONE);
    add_i(12'($urandom), 3'b100, 7'b0010011, ALU_XOR, SRCB_IMM, 1'b0, 1'b0, BR_NONE, MEM_NONE);
    add_i({6'b010000, 6'($urandom)}, 3'b101, 7'b0010011, ALU_SRA, SRCB_IMM, 1'b0, 1'b0,
          BR_NONE, MEM_NONE); // srai with 6-bit shamt
    add_r(7'b0000000, 3'b000, 7'b0110011, ALU_ADD, 1'b0);
    add_r(7'b0100000, 3'b000, 7'b0110011, ALU_SUB, 1'b0);
    add_r(7'b0000000, 3'b011, 7'b0110011, ALU_SLTU, 1'b0);
    add_r(7'b0000000, 3'b111, 7'b0110011, ALU_AND, 1'b0);
    add_i(12'($urandom), 3'b000, 7'b0011011, ALU_ADD, SRCB_IMM, 1'b0, 1'b1, BR_NONE, MEM_NONE);
    add_i({7'b0100000, 5'($urandom)}, 3'b101, 7'b0011011, ALU_SRA, SRCB_IMM, 1'b0, 1'b1,
          BR_NONE, MEM_NONE);
    add_r(7'b0100000, 3'b000, 7'b0111011, ALU_SUB, 1'b1);
    add_r(7'b0000000, 3'b001, 7'b0111011, ALU_SLL, 1'b1);
    // words that must decode to nothing
    push_entry(32'h0000_550b, ALU_INVALID, SRCB_RS2, 1'b0, 1'b0, BR_NONE, MEM_NONE, '0, 1'b1);
    push_entry(32'h02b5_0533, ALU_INVALID, SRCB_RS2, 1'b0, 1'b0, BR_NONE, MEM_NONE, '0, 1'b1);
    push_entry(32'h3402_9073, ALU_INVALID, SRCB_RS2, 1'b0, 1'b0, BR_NONE, MEM_NONE, '0, 1'b1);
    push_entry(32'h0000_0000, ALU_INVALID, SRCB_RS2, 1'b0, 1'b0, BR_NONE, MEM_NONE, '0, 1'b0);
  endtask

  task automatic read_pair(reg_addr_t r, xlen_t exp, string what);
    drive({7'b0, r, r, 3'b000, 5'b0, 7'b1100011}, '0); // beq writes nothing
    wait_level(1'b0);
    check_xlen({what, " rs1"}, o_rs1_data, exp);
    check_xlen({what, " rs2"}, o_rs2_data, exp);
  endtask

  initial begin
    int        ticks;
    ticks = 0;
    while (ticks < 400) begin
      #100;
      ticks++;
    end
    report_timeout("run did not finish");
  end

  initial begin
    reg_addr_t r;
    xlen_t     d;
    string     tag;
    void'($urandom(32'h537c0201));
    errors    = 0;
    checks    = 0;
    i_clk     = 1'b0;
    i_rst     = 1'b1;
    i_inst    = '0;
    i_wb_data = '0;
    repeat (3) wait_level(1'b1);
    #2;
    i_rst = 1'b0;

    for (int i = 0; i < 32; i++) read_pair(reg_addr_t'(i), '0, "after reset");

    build_table();
    foreach (table_q[k]) begin
      drive(table_q[k].inst, '0);
      wait_level(1'b0);
      tag = $sformatf("entry %0d", k);
      check_alu({tag, " alu_ctr"}, o_alu_ctr, table_q[k].alu);
      check_srcb({tag, " alub_src"}, o_alub_src, table_q[k].srcb);
      check_bit({tag, " alua_pc"}, o_alua_pc, table_q[k].pc);
      check_bit({tag, " word_op"}, o_word_op, table_q[k].word);
      check_branch({tag, " branch"}, o_branch, table_q[k].br);
      check_mem_op({tag, " mem_op"}, o_mem_op, table_q[k].mop);
      check_bit({tag, " mem_rd"}, o_mem_rd, table_q[k].inst[6:0] == OPC_LOAD);
      check_bit({tag, " mem_wr"}, o_mem_wr, table_q[k].inst[6:0] == OPC_STORE);
      check_bit({tag, " mem_to_reg"}, o_mem_to_reg, table_q[k].inst[6:0] == OPC_LOAD);
      check_xlen({tag, " imm"}, o_imm, table_q[k].imm);
      check_bit({tag, " invalid"}, o_invalid, table_q[k].inval);
    end

    r = reg_addr_t'(1 + ($urandom % 31));
    d = {$urandom, $urandom};
    drive({12'($urandom), 5'd0, 3'b000, r, 7'b0010011}, d); // addi into r
    read_pair(r, d, "addi write");
    drive({7'b0, 5'd3, 5'd2, 3'b011, r, OPC_STORE}, ~d); // sd, rd field equals r
    read_pair(r, d, "after store");
    drive({12'($urandom), 5'd0, 3'b000, 5'd0, 7'b0010011}, {$urandom, $urandom});
    read_pair(5'd0, '0, "x0 write");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- list.f
logic/idu_pkg.sv
logic/idu_inst_match.sv
logic/idu_imm_gen.sv
logic/idu_ctrl_gen.sv
logic/idu_gpr_file.sv
logic/idu.sv
test/tb_idu_assert.sv
test/tb_idu.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_idu -o tb_idu_sim \
  && ./obj_dir/tb_idu_sim 2>&1 | tee sim.log \
  || { echo "build or simulation run failed"; exit 1; }

grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST OK" sim.log || { echo "run ended without a result line"; exit 1; }
exit 0
